// File: hw/obi_integrity_pkg.sv
// Shared bus types and field widths for the memory-side integrity front end
// Import into every block that touches a request or a response payload
package obi_integrity_pkg;

  ////////////////////
  // Field widths
  ////////////////////

  // Address and data widths of both ports and of the shared bus
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;

  // Address-phase checksum and response checksum widths
  localparam int unsigned ACHK_W = 12;
  localparam int unsigned RCHK_W = 5;

  ////////////////////
  // Bus types
  ////////////////////

  // Bit 0 marks a bufferable access, bit 1 a cacheable one
  typedef logic [1:0] memtype_t;

  // Privilege, data/instruction and secure bits of the access
  typedef logic [2:0] prot_t;

  // Request payload carried by both ports and by the shared bus
  // The instruction port only fills addr, memtype, prot and dbg
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
    memtype_t          memtype;
    prot_t             prot;
    logic              dbg;
  } obi_req_t;

  // Response payload routed back to the issuing port
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } obi_resp_t;

  // Port that owns an outstanding transaction
  typedef enum logic {
    OWNER_INSTR = 1'b0,
    OWNER_DATA  = 1'b1
  } owner_e;

endpackage

// File: hw/obi_arbiter.sv
// Fixed-priority arbiter that merges the fetch and load/store ports onto one bus
// An owner FIFO remembers grant order so each response goes back to its issuer
`timescale 1ns/10ps

module obi_arbiter
  import obi_integrity_pkg::*;
#(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic              clk,
  input  logic              rst_ni,

  input  logic              instr_req_i,
  input  logic [ADDR_W-1:0] instr_addr_i,
  input  memtype_t          instr_memtype_i,
  input  prot_t             instr_prot_i,
  input  logic              instr_dbg_i,

  input  logic              data_req_i,
  input  obi_req_t          data_payload_i,

  output logic              instr_gnt_o,
  output logic              data_gnt_o,

  output logic              bus_req_o,
  output obi_req_t          bus_payload_o,
  input  logic              bus_gnt_i,
  input  logic              bus_rvalid_i,

  output owner_e            resp_owner_o
);

  // A depth of one still needs a one-bit pointer
  localparam int unsigned PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

  obi_req_t         instr_payload;
  owner_e           owner_q [MAX_OUTSTANDING];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  ////////////////////
  // Request side
  ////////////////////

  // Fetches are full-word reads and never bufferable
  always_comb begin
    instr_payload         = '0;
    instr_payload.addr    = instr_addr_i;
    instr_payload.we      = 1'b0;
    instr_payload.be      = '1;
    instr_payload.wdata   = '0;
    instr_payload.memtype = {instr_memtype_i[1], 1'b0};
    instr_payload.prot    = instr_prot_i;
    instr_payload.dbg     = instr_dbg_i;
  end

  assign full  = (cnt_q == CNT_W'(MAX_OUTSTANDING));
  assign empty = (cnt_q == '0);

  // Load/store wins a same-cycle conflict; the loser keeps its request up
  assign bus_req_o     = (instr_req_i | data_req_i) & ~full;
  assign bus_payload_o = data_req_i ? data_payload_i : instr_payload;

  assign data_gnt_o  = bus_req_o & bus_gnt_i & data_req_i;
  assign instr_gnt_o = bus_req_o & bus_gnt_i & ~data_req_i;

  ////////////////////
  // Owner queue
  ////////////////////

  assign push = bus_req_o & bus_gnt_i;
  assign pop  = bus_rvalid_i;

  // Head of the queue is the owner of the next response on the bus
  assign resp_owner_o = owner_q[rd_ptr_q];

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the fill level unchanged
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Entries are only read after they have been written
  always_ff @(posedge clk) begin
    if (push) begin
      owner_q[wr_ptr_q] <= data_req_i ? OWNER_DATA : OWNER_INSTR;
    end
  end

  // The memory may only answer transactions that were granted earlier
  a_no_rvalid_when_empty : assert property (@(posedge clk) disable iff (!rst_ni)
    bus_rvalid_i |-> !empty)
    else $error("Response without an outstanding transaction");

  // A grant from the memory must never overrun the owner queue
  a_no_push_when_full : assert property (@(posedge clk) disable iff (!rst_ni)
    cnt_q <= CNT_W'(MAX_OUTSTANDING))
    else $error("Owner queue overflow");

endmodule

// File: hw/obi_achk_encoder.sv
// Request parity and address-phase checksum generator for the shared bus
// Purely combinational, sits between the arbiter output and the bus pins
`timescale 1ns/10ps

module obi_achk_encoder
  import obi_integrity_pkg::*;
(
  input  logic              bus_req_i,
  input  obi_req_t          bus_payload_i,
  output logic              bus_reqpar_o,
  output logic [ACHK_W-1:0] bus_achk_o
);

  logic [BE_W-1:0] wdata_par;
  logic [BE_W-1:0] addr_par;
  logic            instr_like;

  // Even parity per byte lane, lane 0 in bit 0
  always_comb begin
    for (int i = 0; i < BE_W; i++) begin
      wdata_par[i] = ^bus_payload_i.wdata[8*i +: 8];
      addr_par[i]  = ^bus_payload_i.addr[8*i +: 8];
    end
  end

  // Request parity is simply the inverted strobe
  assign bus_reqpar_o = ~bus_req_i;

  ////////////////////
  // Checksum packing
  ////////////////////

  // Bits 11:8 cover wdata, bit 7 is reserved as zero
  // Bits 6:4 use inverted parity so an all-zero bus is caught
  // Bits 3:0 cover the address bytes
  assign bus_achk_o = {
    wdata_par,
    1'b0,
    ~^bus_payload_i.dbg,
    ~^{bus_payload_i.be, bus_payload_i.we},
    ~^{bus_payload_i.prot, bus_payload_i.memtype},
    addr_par
  };

  // A fetch shows up as a full-word read with zero write data
  assign instr_like = bus_req_i && !bus_payload_i.we &&
                      (bus_payload_i.be == '1) && (bus_payload_i.wdata == '0) &&
                      !bus_payload_i.prot[0];

  // Fetches leave the arbiter with the bufferable bit cleared
  always_comb begin
    if (instr_like) begin
      a_instr_not_bufferable : assert (!bus_payload_i.memtype[0])
        else $error("Instruction request marked bufferable");
    end
  end

endmodule

// File: hw/obi_rchk_checker.sv
// Response integrity checker for the shared bus
// Routes each response to its owner and raises a registered integrity alert
`timescale 1ns/10ps

module obi_rchk_checker
  import obi_integrity_pkg::*;
(
  input  logic              clk,
  input  logic              rst_ni,

  input  logic              bus_gnt_i,
  input  logic              bus_gntpar_i,
  input  logic              bus_rvalid_i,
  input  logic              bus_rvalidpar_i,
  input  logic [DATA_W-1:0] bus_rdata_i,
  input  logic              bus_err_i,
  input  logic [RCHK_W-1:0] bus_rchk_i,

  input  owner_e            resp_owner_i,

  output logic              instr_rvalid_o,
  output logic              data_rvalid_o,
  output obi_resp_t         instr_resp_o,
  output obi_resp_t         data_resp_o,

  output logic              integrity_alert_o
);

  logic [RCHK_W-1:0] rchk_exp;
  logic              rchk_err;
  logic              gntpar_err;
  logic              rvalidpar_err;
  obi_resp_t         resp;

  // Expected checksum has one parity bit per rdata byte and the err parity on top
  always_comb begin
    rchk_exp[RCHK_W-1] = ^bus_err_i;
    for (int i = 0; i < DATA_W / 8; i++) begin
      rchk_exp[i] = ^bus_rdata_i[8*i +: 8];
    end
  end

  // Checksum only counts while a response is actually on the bus
  assign rchk_err      = bus_rvalid_i && (bus_rchk_i != rchk_exp);
  assign gntpar_err    = (bus_gntpar_i == bus_gnt_i);
  assign rvalidpar_err = (bus_rvalidpar_i == bus_rvalid_i);

  // A corrupted response is still delivered, but flagged as an error
  assign resp.rdata = bus_rdata_i;
  assign resp.err   = bus_err_i | rchk_err;

  assign instr_resp_o = resp;
  assign data_resp_o  = resp;

  // The owner queue head selects which port sees the strobe
  assign instr_rvalid_o = bus_rvalid_i && (resp_owner_i == OWNER_INSTR);
  assign data_rvalid_o  = bus_rvalid_i && (resp_owner_i == OWNER_DATA);

  ////////////////////
  // Integrity alert
  ////////////////////

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      integrity_alert_o <= 1'b0;
    end else begin
      integrity_alert_o <= rchk_err | gntpar_err | rvalidpar_err;
    end
  end

  // Each response belongs to exactly one port, named by a written queue entry
  a_single_owner : assert property (@(posedge clk) disable iff (!rst_ni)
    bus_rvalid_i |-> !$isunknown(resp_owner_i))
    else $error("Response with no known owner");

endmodule

// File: hw/obi_integrity_top.sv
// Top level of the memory-side integrity front end
// Connects both core ports through the arbiter, encoder and checker to one bus
`timescale 1ns/10ps

module obi_integrity_top
  import obi_integrity_pkg::*;
#(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic              clk,
  input  logic              rst_ni,

  // Instruction fetch port
  input  logic              instr_req_i,
  input  logic [ADDR_W-1:0] instr_addr_i,
  input  memtype_t          instr_memtype_i,
  input  prot_t             instr_prot_i,
  input  logic              instr_dbg_i,
  output logic              instr_gnt_o,
  output logic              instr_rvalid_o,
  output obi_resp_t         instr_resp_o,

  // Load/store port
  input  logic              data_req_i,
  input  obi_req_t          data_payload_i,
  output logic              data_gnt_o,
  output logic              data_rvalid_o,
  output obi_resp_t         data_resp_o,

  // Shared memory bus
  output logic              bus_req_o,
  output logic              bus_reqpar_o,
  output logic [ACHK_W-1:0] bus_achk_o,
  output obi_req_t          bus_payload_o,
  input  logic              bus_gnt_i,
  input  logic              bus_gntpar_i,
  input  logic              bus_rvalid_i,
  input  logic              bus_rvalidpar_i,
  input  logic [DATA_W-1:0] bus_rdata_i,
  input  logic              bus_err_i,
  input  logic [RCHK_W-1:0] bus_rchk_i,

  output logic              integrity_alert_o
);

  owner_e resp_owner;

  obi_arbiter #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_arbiter (
    .clk             (clk),
    .rst_ni          (rst_ni),
    .instr_req_i     (instr_req_i),
    .instr_addr_i    (instr_addr_i),
    .instr_memtype_i (instr_memtype_i),
    .instr_prot_i    (instr_prot_i),
    .instr_dbg_i     (instr_dbg_i),
    .data_req_i      (data_req_i),
    .data_payload_i  (data_payload_i),
    .instr_gnt_o     (instr_gnt_o),
    .data_gnt_o      (data_gnt_o),
    .bus_req_o       (bus_req_o),
    .bus_payload_o   (bus_payload_o),
    .bus_gnt_i       (bus_gnt_i),
    .bus_rvalid_i    (bus_rvalid_i),
    .resp_owner_o    (resp_owner)
  );

  // Checksum is computed on the payload that actually leaves the arbiter
  obi_achk_encoder u_achk_encoder (
    .bus_req_i     (bus_req_o),
    .bus_payload_i (bus_payload_o),
    .bus_reqpar_o  (bus_reqpar_o),
    .bus_achk_o    (bus_achk_o)
  );

  obi_rchk_checker u_rchk_checker (
    .clk               (clk),
    .rst_ni            (rst_ni),
    .bus_gnt_i         (bus_gnt_i),
    .bus_gntpar_i      (bus_gntpar_i),
    .bus_rvalid_i      (bus_rvalid_i),
    .bus_rvalidpar_i   (bus_rvalidpar_i),
    .bus_rdata_i       (bus_rdata_i),
    .bus_err_i         (bus_err_i),
    .bus_rchk_i        (bus_rchk_i),
    .resp_owner_i      (resp_owner),
    .instr_rvalid_o    (instr_rvalid_o),
    .data_rvalid_o     (data_rvalid_o),
    .instr_resp_o      (instr_resp_o),
    .data_resp_o       (data_resp_o),
    .integrity_alert_o (integrity_alert_o)
  );

endmodule

// File: test/tb_obi_integrity.sv
// Testbench for the integrity front end, with a small in-order bus memory model
// Drives both core ports, answers on the shared bus and checks every response
`timescale 1ns/10ps

module tb_obi_integrity
  import obi_integrity_pkg::*;
();

  // Expected response as seen by the issuing port
  typedef struct packed {
    logic              is_read;
    logic [DATA_W-1:0] rdata;
    logic              err;
  } exp_resp_t;

  // Response waiting in the memory model until its due cycle
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              corrupt;
    logic [31:0]       due;
  } mem_resp_t;

  // Lengths of the mix, priority, corruption, parity and stall tests in cycles
  localparam int unsigned TEST_LEN_SUM = 320 + 20 + 20 + 30 + 80;
  localparam int unsigned MAX_CYCLES   = 2 * TEST_LEN_SUM + 100;

  logic clk, rst_ni;
  logic instr_req_i, instr_dbg_i, instr_gnt_o, instr_rvalid_o;
  logic [ADDR_W-1:0] instr_addr_i;
  memtype_t instr_memtype_i;
  prot_t instr_prot_i;
  obi_resp_t instr_resp_o, data_resp_o;
  logic data_req_i, data_gnt_o, data_rvalid_o;
  obi_req_t data_payload_i, bus_payload_o;
  logic bus_req_o, bus_reqpar_o, bus_gnt_i, bus_gntpar_i, bus_rvalid_i, bus_rvalidpar_i;
  logic [ACHK_W-1:0] bus_achk_o;
  logic [DATA_W-1:0] bus_rdata_i;
  logic bus_err_i, integrity_alert_o;
  logic [RCHK_W-1:0] bus_rchk_i;

  logic [DATA_W-1:0] mem [256];
  logic [DATA_W-1:0] ref_mem [256];
  obi_req_t instr_q [$];
  obi_req_t data_q [$];
  exp_resp_t exp_instr [$];
  exp_resp_t exp_data [$];
  mem_resp_t resp_q [$];
  logic grant_log [$];
  logic [31:0] seed, cyc;
  int err_cnt, chk_cnt, alert_cnt, test_cnt;
  logic corrupt_arm, stall_force, gntpar_flip, rvalidpar_flip, alert_exp;
  logic fault_q;

  obi_integrity_top UUT (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  ////////////////////
  // Reference functions
  ////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = lcg_next(seed);
    return seed;
  endfunction

  // Every word of the initial image is distinct across the whole index
  function automatic logic [DATA_W-1:0] fill_word(input logic [7:0] idx);
    return {idx ^ 8'h5a, ~idx, idx * 8'd37, idx + 8'h11};
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
      input logic [DATA_W-1:0] new_w, input logic [BE_W-1:0] be);
    logic [DATA_W-1:0] w;
    w = old_w;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) w[8*b +: 8] = new_w[8*b +: 8];
    end
    return w;
  endfunction

  // Address checksum with wdata parity on top, then zero, dbg, be/we, prot/memtype and addr
  function automatic logic [ACHK_W-1:0] ref_achk(input obi_req_t p);
    logic [ACHK_W-1:0] a;
    a = '0;
    for (int b = 0; b < 4; b++) begin
      a[8 + b] = ^p.wdata[8*b +: 8];
      a[b]     = ^p.addr[8*b +: 8];
    end
    a[6] = ~p.dbg;
    a[5] = ~(^{p.be, p.we});
    a[4] = ~(^{p.prot, p.memtype});
    return a;
  endfunction

  function automatic logic [RCHK_W-1:0] ref_rchk(input logic [DATA_W-1:0] d, input logic e);
    logic [RCHK_W-1:0] r;
    r[4] = e;
    for (int b = 0; b < 4; b++) r[b] = ^d[8*b +: 8];
    return r;
  endfunction

  // Addresses hit only 16 words so reads often see earlier writes
  function automatic obi_req_t rand_req(input logic is_data);
    obi_req_t p;
    logic [31:0] r;
    r = next_rand();
    p.addr = {r[31:14], 8'h00, r[13:10], 2'b00};
    r = next_rand();
    p.we      = is_data & r[31];
    p.be      = r[27:24];
    p.memtype = r[23:22];
    p.prot    = r[21:19];
    p.dbg     = r[18];
    p.wdata   = next_rand();
    return p;
  endfunction

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_resp(input string port, input obi_resp_t got, input exp_resp_t e);
    if (e.is_read) check_eq({port, " rdata"}, got.rdata, e.rdata);
    check_eq({port, " err"}, got.err, e.err);
  endtask

  // Idle means every queued request was granted and answered
  task automatic wait_idle();
    do @(negedge clk);
    while (instr_q.size() > 0 || data_q.size() > 0 || instr_req_i || data_req_i ||
           exp_instr.size() > 0 || exp_data.size() > 0);
  endtask

  task automatic report_test(input string name, input int base_err);
    test_cnt++;
    $display("%-32s finished with %0d errors", name, err_cnt - base_err);
  endtask

  ////////////////////
  // Port drivers and memory model
  ////////////////////

  always @(posedge clk) begin
    exp_resp_t e;
    mem_resp_t m;
    obi_req_t p;
    logic [7:0] idx;
    logic [31:0] r;
    logic g, rv, fault;
    if (rst_ni) begin
      r = next_rand();
      // Expected results follow grant order, which is also the memory access order
      if (instr_gnt_o) begin
        e.is_read = 1'b1;
        e.rdata   = ref_mem[instr_addr_i[9:2]];
        e.err     = corrupt_arm;
        exp_instr.push_back(e);
        grant_log.push_back(1'b0);
      end
      if (data_gnt_o) begin
        idx       = data_payload_i.addr[9:2];
        e.is_read = !data_payload_i.we;
        e.rdata   = ref_mem[idx];
        e.err     = corrupt_arm;
        if (data_payload_i.we) begin
          ref_mem[idx] = merge_bytes(ref_mem[idx], data_payload_i.wdata, data_payload_i.be);
        end
        exp_data.push_back(e);
        grant_log.push_back(1'b1);
      end
      // The memory sees only the shared bus and answers 1 to 3 cycles after the grant
      if (bus_req_o && bus_gnt_i) begin
        idx     = bus_payload_o.addr[9:2];
        m.rdata = bus_payload_o.we ? '0 : mem[idx];
        if (bus_payload_o.we) begin
          mem[idx] = merge_bytes(mem[idx], bus_payload_o.wdata, bus_payload_o.be);
        end
        m.corrupt   = corrupt_arm;
        corrupt_arm = 1'b0;
        m.due       = cyc + {30'd0, r[31:30] % 2'd3};
        resp_q.push_back(m);
      end
      rv = (resp_q.size() > 0) && (cyc >= resp_q[0].due);
      // Every fault injected on this edge is remembered for the alert check
      fault = gntpar_flip;
      if (rv) begin
        m = resp_q.pop_front();
        bus_rdata_i <= m.rdata;
        bus_rchk_i  <= ref_rchk(m.rdata, 1'b0) ^ {4'b0000, m.corrupt};
        fault       = fault | m.corrupt | rvalidpar_flip;
      end else begin
        bus_rdata_i <= '0;
        bus_rchk_i  <= '0;
      end
      bus_rvalid_i    <= rv;
      // A pending rvalidpar fault waits for a response so its data can be checked
      bus_rvalidpar_i <= ~rv ^ (rv & rvalidpar_flip);
      if (rv) rvalidpar_flip = 1'b0;
      // Random grant stall or a forced stall for the back-pressure test
      g = !stall_force && (r[29:28] != 2'b00);
      bus_gnt_i    <= g;
      bus_gntpar_i <= ~g ^ gntpar_flip;
      gntpar_flip  = 1'b0;
      fault_q      <= fault;
      // A port moves to its next request only once the current one is granted
      if (!instr_req_i || instr_gnt_o) begin
        instr_req_i <= (instr_q.size() > 0);
        if (instr_q.size() > 0) begin
          p = instr_q.pop_front();
          instr_addr_i    <= p.addr;
          instr_memtype_i <= p.memtype;
          instr_prot_i    <= p.prot;
          instr_dbg_i     <= p.dbg;
        end
      end
      if (!data_req_i || data_gnt_o) begin
        data_req_i <= (data_q.size() > 0);
        if (data_q.size() > 0) data_payload_i <= data_q.pop_front();
      end
    end
    cyc <= cyc + 1;
  end

  ////////////////////
  // Compare process
  ////////////////////

  always @(posedge clk) begin
    exp_resp_t e;
    if (rst_ni) begin
      // A fault driven at one edge shows on the registered alert two edges later
      check_eq("integrity alert", integrity_alert_o, alert_exp);
      if (integrity_alert_o) alert_cnt++;
      alert_exp = fault_q;
      check_eq("reqpar", bus_reqpar_o, !bus_req_o);
      if (bus_req_o) begin
        check_eq("achk", bus_achk_o, ref_achk(bus_payload_o));
        if (!data_req_i) begin
          check_eq("fetch we", bus_payload_o.we, 1'b0);
          check_eq("fetch be", bus_payload_o.be, 4'hf);
          check_eq("fetch wdata", bus_payload_o.wdata, '0);
          check_eq("fetch bufferable", bus_payload_o.memtype[0], 1'b0);
        end
      end
      if (instr_req_i && data_req_i) check_eq("fetch gnt beside data req", instr_gnt_o, 1'b0);
      if (instr_rvalid_o) begin
        if (exp_instr.size() == 0) begin
          $display("Fetch port got a response with no fetch outstanding at %0t", $time);
          err_cnt++;
        end else begin
          e = exp_instr.pop_front();
          check_resp("fetch", instr_resp_o, e);
        end
      end
      if (data_rvalid_o) begin
        if (exp_data.size() == 0) begin
          $display("Data port got a response with no access outstanding at %0t", $time);
          err_cnt++;
        end else begin
          e = exp_data.pop_front();
          check_resp("data", data_resp_o, e);
        end
      end
    end
  end

  always @(negedge clk) begin
    if (cyc >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, requests never completed", cyc);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    int base_err;
    int base_alert;
    obi_req_t p;
    instr_req_i = 1'b0;
    instr_addr_i = '0;
    instr_memtype_i = '0;
    instr_prot_i = '0;
    instr_dbg_i = 1'b0;
    data_req_i = 1'b0;
    data_payload_i = '0;
    bus_gnt_i = 1'b0;
    bus_gntpar_i = 1'b1;
    bus_rvalid_i = 1'b0;
    bus_rvalidpar_i = 1'b1;
    bus_rdata_i = '0;
    bus_err_i = 1'b0;
    bus_rchk_i = '0;
    seed = 32'hf573_f10c;
    cyc = '0;
    {corrupt_arm, stall_force, gntpar_flip, rvalidpar_flip, alert_exp, fault_q} = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i]     = fill_word(8'(i));
      ref_mem[i] = fill_word(8'(i));
    end
    rst_ni = 1'b0;
    repeat (3) @(posedge clk);
    rst_ni <= 1'b1;
    @(negedge clk);

    base_err = err_cnt;
    for (int i = 0; i < 40; i++) begin
      data_q.push_back(rand_req(1'b1));
      instr_q.push_back(rand_req(1'b0));
    end
    wait_idle();
    report_test("random mix and checksums", base_err);

    // Both ports raise req in the same cycle
    base_err = err_cnt;
    grant_log.delete();
    instr_q.push_back(rand_req(1'b0));
    p = rand_req(1'b1);
    data_q.push_back(p);
    wait_idle();
    if (grant_log.size() > 0) check_eq("first grant owner", grant_log[0], 1'b1);
    report_test("data over fetch priority", base_err);

    // First read answers with a bad rchk and the second one is clean
    base_err = err_cnt;
    base_alert = alert_cnt;
    corrupt_arm = 1'b1;
    p.we = 1'b0;
    data_q.push_back(p);
    data_q.push_back(p);
    wait_idle();
    repeat (2) @(negedge clk);
    check_eq("alert pulses after bad rchk", alert_cnt - base_alert, 1);
    report_test("response checksum error", base_err);

    // Parity faults land on the first request cycle and on the first response
    base_err = err_cnt;
    base_alert = alert_cnt;
    gntpar_flip = 1'b1;
    rvalidpar_flip = 1'b1;
    data_q.push_back(rand_req(1'b1));
    instr_q.push_back(rand_req(1'b0));
    wait_idle();
    repeat (2) @(negedge clk);
    check_eq("alert pulses after parity faults", alert_cnt - base_alert, 2);
    report_test("handshake parity faults", base_err);

    // A long grant stall, after which everything queued must still complete
    base_err = err_cnt;
    stall_force = 1'b1;
    for (int i = 0; i < 4; i++) begin
      data_q.push_back(rand_req(1'b1));
      instr_q.push_back(rand_req(1'b0));
    end
    repeat (40) @(negedge clk);
    check_eq("grants during stall", exp_instr.size() + exp_data.size(), 0);
    stall_force = 1'b0;
    wait_idle();
    report_test("grant back-pressure", base_err);

    $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: build.f
hw/obi_integrity_pkg.sv
hw/obi_arbiter.sv
hw/obi_achk_encoder.sv
hw/obi_rchk_checker.sv
hw/obi_integrity_top.sv
test/tb_obi_integrity.sv

// File: Makefile
# Verilator build and run of the integrity front end testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_obi_integrity \
		-f build.f -o tb_obi_integrity
	./obj_dir/tb_obi_integrity | tee sim.log
	@if grep -q "Test failed" sim.log || ! grep -q "Test passed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
